// File: rtl/aes_enc.sv
module aes_enc import aes_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  key_load,
    input  logic [block_bits-1:0] key,
    output logic                  key_ready,
    input  logic                  in_valid,
    input  logic [block_bits-1:0] in_block,
    output logic                  in_ready,
    output logic                  out_valid,
    output logic [block_bits-1:0] out_block
);

    logic                  key_start;
    logic                  key_en;
    logic                  key_done;
    logic                  key_loaded;
    logic                  key_idle;
    logic                  in_accept;
    logic [3:0]            round_idx;
    logic [block_bits-1:0] round_key;
    logic [num_keys-1:0]   key_wen;
    logic [block_bits-1:0] key_bank [num_keys];
    logic [num_keys-1:0]   valid_q;  // bit i marks a block in stage i.
    logic [block_bits-1:0] r0_q;
    logic [block_bits-1:0] chain [num_keys];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshakes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // a new key waits for an idle expander and an empty pipeline.
    // the first load is taken while key_ready is still low, since no key is held yet.
    assign key_idle  = !key_en && !(|valid_q);
    assign key_start = key_load && key_idle;
    assign key_ready = key_idle && key_loaded;
    assign in_ready  = key_loaded && !key_en;  // blocks stream freely between key loads.
    assign in_accept = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            key_loaded <= 1'b0;
        end else if (key_done) begin
            key_loaded <= 1'b1;
        end
    end

    key_sched_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .key_start (key_start),
        .key_en    (key_en),
        .round_idx (round_idx),
        .key_done  (key_done)
    );

    key_expander u_keyexp (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .key_start (key_start),
        .key_en    (key_en),
        .round_idx (round_idx),
        .round_key (round_key)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // round-key bank
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign key_wen = key_en ? ({{(num_keys-1){1'b0}}, 1'b1} << round_idx) : '0;

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < num_keys; i++) begin
                key_bank[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_keys; i++) begin
                if (key_wen[i]) begin
                    key_bank[i] <= round_key;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[num_keys-2:0], in_accept};
        end
    end

    always_ff @(posedge clk) begin
        if (in_accept) begin
            r0_q <= in_block ^ key_bank[0];  // initial AddRoundKey.
        end
    end

    assign chain[0] = r0_q;

    for (genvar i = 1; i < num_keys; i++) begin : g_round
        aes_round #(
            .last_round (i == num_rounds)
        ) u_round (
            .clk       (clk),
            .rst       (rst),
            .state_in  (chain[i-1]),
            .round_key (key_bank[i]),
            .valid_in  (valid_q[i-1]),
            .state_out (chain[i])
        );
    end

    assign out_valid = valid_q[num_rounds];
    assign out_block = chain[num_rounds];

endmodule

// File: rtl/aes_pkg.sv
package aes_pkg;

    localparam int block_bits = 128;  // block and key width.
    localparam int num_rounds = 10;
    localparam int num_keys   = num_rounds + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // forward S-box, entry 0 in the top byte.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [0:255][7:0] sbox_tbl = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // the same 128 bits seen as one word or as 16 bytes.
    // bytes[0] is the top byte, so bytes[4*c + r] is row r of column c.
    typedef union packed {
        logic [block_bits-1:0]            word;
        logic [0:block_bits/8-1][7:0]     bytes;
    } aes_state_u;

    function automatic logic [7:0] sbox(input logic [7:0] b);
        return sbox_tbl[b];
    endfunction

    // round constant for key index 1 to 10.
    function automatic logic [7:0] rcon(input logic [3:0] idx);
        case (idx)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);  // reduce by x^8+x^4+x^3+x+1.
    endfunction

endpackage

// File: rtl/aes_round.sv
module aes_round import aes_pkg::*; #(
    parameter bit last_round = 1'b0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [block_bits-1:0] state_in,
    input  logic [block_bits-1:0] round_key,
    input  logic                  valid_in,
    output logic [block_bits-1:0] state_out
);

    aes_state_u            s_in;
    aes_state_u            s_sub;
    aes_state_u            s_shift;
    aes_state_u            s_mix;
    logic [block_bits-1:0] state_q;

    assign s_in.word = state_in;

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            s_sub.bytes[i] = sbox(s_in.bytes[i]);
        end
    end

    // row r rotates left by r columns.
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                s_shift.bytes[4*c + r] = s_sub.bytes[4*((c + r) % 4) + r];
            end
        end
    end

    if (last_round) begin : g_last
        assign s_mix = s_shift;  // the last round has no MixColumns.
    end else begin : g_mix
        always_comb begin
            logic [0:3][7:0] col;
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    col[r] = s_shift.bytes[4*c + r];
                end
                // 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3].
                for (int r = 0; r < 4; r++) begin
                    s_mix.bytes[4*c + r] = xtime(col[r] ^ col[(r + 1) % 4]) ^ col[(r + 1) % 4]
                                         ^ col[(r + 2) % 4] ^ col[(r + 3) % 4];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= '0;
        end else if (valid_in) begin
            state_q <= s_mix.word ^ round_key;
        end
    end

    assign state_out = state_q;

endmodule

// File: rtl/key_expander.sv
module key_expander import aes_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [block_bits-1:0] key,
    input  logic                  key_start,
    input  logic                  key_en,
    input  logic [3:0]            round_idx,
    output logic [block_bits-1:0] round_key
);

    logic [block_bits-1:0] key_q;
    logic [31:0]           w0;
    logic [31:0]           w1;
    logic [31:0]           w2;
    logic [31:0]           w3;
    logic [31:0]           rot_w;
    logic [31:0]           temp_w;
    logic [31:0]           n0;
    logic [31:0]           n1;
    logic [31:0]           n2;
    logic [31:0]           n3;

    assign {w0, w1, w2, w3} = key_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next round key from the one held.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rot_w  = {w3[23:0], w3[31:24]};
    assign temp_w = {sbox(rot_w[31:24]), sbox(rot_w[23:16]),
                     sbox(rot_w[15:8]), sbox(rot_w[7:0])}
                  ^ {rcon(round_idx + 4'd1), 24'h000000};

    assign n0 = w0 ^ temp_w;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    always_ff @(posedge clk) begin
        if (!rst) begin
            key_q <= '0;
        end else if (key_start) begin
            key_q <= key;  // key 0 is the cipher key itself.
        end else if (key_en && round_idx != 4'(num_rounds)) begin
            key_q <= {n0, n1, n2, n3};
        end
    end

    assign round_key = key_q;

endmodule

// File: rtl/key_sched_ctrl.sv
module key_sched_ctrl import aes_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       key_start,
    output logic       key_en,
    output logic [3:0] round_idx,
    output logic       key_done
);

    logic running;    // low is idle, high is run.
    logic last_step;

    assign last_step = running && (round_idx == 4'(num_rounds));

    always_ff @(posedge clk) begin
        if (!rst) begin
            running   <= 1'b0;
            round_idx <= 4'd0;
        end else if (!running) begin
            if (key_start) begin
                running   <= 1'b1;
                round_idx <= 4'd0;
            end
        end else if (last_step) begin
            running <= 1'b0;  // round_idx holds at 10 while idle.
        end else begin
            round_idx <= round_idx + 4'd1;
        end
    end

    // one key per cycle while running, indices 0 to 10.
    assign key_en   = running;
    assign key_done = last_step;

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the AES-128 testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_aes_enc -f sources.f -o sim_aes_enc

# a failing check must not stop the run before the closing report.
output=$(./obj_dir/sim_aes_enc +verilator+error+limit+1000) || true
echo "$output"

if grep -qF '*** PASSED ***' <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: sources.f
rtl/aes_pkg.sv
rtl/key_sched_ctrl.sv
rtl/key_expander.sv
rtl/aes_round.sv
rtl/aes_enc.sv
tests/aes_enc_chk.sv
tests/tb_aes_enc.sv

// File: tests/aes_enc_chk.sv
module aes_enc_chk import aes_pkg::*; (
    input logic                clk,
    input logic                rst,
    input logic                key_start,
    input logic                key_en,
    input logic                key_ready,
    input logic                in_valid,
    input logic                in_ready,
    input logic                out_valid,
    input logic [num_keys-1:0] valid_q
);

    int fail_count = 0;  // failed assertions so far.

    // a block leaves exactly 11 cycles after it was taken.
    latency_a: assert property (@(posedge clk) disable iff (!rst)
        in_valid && in_ready |-> ##11 out_valid)
        else begin
            fail_count++;
            $error("out_valid missing 11 cycles after an accepted block");
        end

    no_extra_a: assert property (@(posedge clk) disable iff (!rst)
        out_valid |-> $past(in_valid && in_ready, 11))
        else begin
            fail_count++;
            $error("out_valid without a block accepted 11 cycles before");
        end

    // expansion takes indices 0 to 10 and then one cycle to settle.
    key_ready_a: assert property (@(posedge clk) disable iff (!rst)
        key_start |-> ##12 $rose(key_ready))
        else begin
            fail_count++;
            $error("key_ready did not rise 12 cycles after the key load");
        end

    // no block is taken while the eleven round keys are written.
    for (genvar d = 1; d <= num_keys; d++) begin : g_in_ready
        in_ready_a: assert property (@(posedge clk) disable iff (!rst)
            key_start |-> ##d !in_ready)
            else begin
                fail_count++;
                $error("in_ready high while the key expansion runs");
            end
    end

    reset_a: assert property (@(posedge clk)
        !rst |=> !out_valid && !key_en && valid_q == '0 && !key_ready && !in_ready)
        else begin
            fail_count++;
            $error("pipeline or handshake not idle after reset");
        end

endmodule

bind aes_enc aes_enc_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .key_start (key_start),
    .key_en    (key_en),
    .key_ready (key_ready),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .valid_q   (valid_q)
);

// File: tests/tb_aes_enc.sv
module tb_aes_enc import aes_pkg::*; ();

    // about twice 5 + 3*12 + 32*4 + 4*11 cycles of reset, key loads, gapped blocks and drains.
    localparam int max_cycles = 400;

    localparam logic [127:0] c1_key = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] c1_pt  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] c1_ct  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam logic [127:0] b_key  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam logic [127:0] zero_ct = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

    // appendix B block first, then the ECB blocks under the same key.
    localparam logic [127:0] b_pt [5] = '{
        128'h3243f6a8885a308d313198a2e0370734, 128'h6bc1bee22e409f96e93d7e117393172a,
        128'hae2d8a571e03ac9c9eb76fac45af8e51, 128'h30c81c46a35ce411e5fbc1191a0a52ef,
        128'hf69f2445df4f9b17ad2b417be66c3710};
    localparam logic [127:0] b_ct [5] = '{
        128'h3925841d02dc09fbdc118597196a0b32, 128'h3ad77bb40d7a3660a89ecaf32466ef97,
        128'hf5d3d58503b9699de785895a96fdbaaf, 128'h43b1cd7f598ece23881b00e3ed030688,
        128'h7b0c785e27e8ad3f8223207104725dd4};

    logic                  clk;
    logic                  rst;
    logic                  key_load;
    logic [block_bits-1:0] key;
    logic                  key_ready;
    logic                  in_valid;
    logic [block_bits-1:0] in_block;
    logic                  in_ready;
    logic                  out_valid;
    logic [block_bits-1:0] out_block;
    logic [block_bits-1:0] cur_exp;    // ciphertext of the block being driven.
    logic [block_bits-1:0] exp_block;
    logic [block_bits-1:0] exp_q [$];
    int                    errors = 0;
    int                    cycle_count;

    aes_enc u_dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // poke is the number of cycles a refused block is offered during expansion.
    task automatic load_key(input logic [127:0] k, input int poke);
        int n;
        n = 0;
        key_load <= 1'b1;
        key      <= k;
        @(posedge clk);
        key_load <= 1'b0;
        in_valid <= (poke > 0);
        in_block <= ~k;
        do begin
            @(posedge clk);
            n++;
            if (n >= poke) in_valid <= 1'b0;
        end while (!key_ready);
        assert (n == 12)
        else begin
            errors++;
            $error("MISMATCH time %0t key_ready latency got %0d expected 12", $time, n);
        end
    endtask

    task automatic send_block(input logic [127:0] pt, input logic [127:0] ct);
        in_valid <= 1'b1;
        in_block <= pt;
        cur_exp  <= ct;
        do begin
            @(posedge clk);
        end while (!in_ready);  // taken on the edge where in_ready is seen high.
    endtask

    task automatic idle_cycles(input int n);
        in_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic drain_pipeline();
        in_valid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!key_ready);
    endtask

    task automatic finish_run(input bit timed_out);
        int chk_fails;
        chk_fails = u_dut.u_chk.fail_count;
        $display("closing report: %0d errors, %0d assertion failures", errors, chk_fails);
        if (!timed_out && errors == 0 && chk_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // expected results
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (out_valid) begin
            assert (exp_q.size() != 0)
            else begin
                errors++;
                $error("out_valid at time %0t with no block in flight", $time);
            end
            if (exp_q.size() != 0) begin
                exp_block = exp_q.pop_front();
                assert (out_block == exp_block)
                else begin
                    errors++;
                    $error("MISMATCH time %0t out_block got %h expected %h",
                           $time, out_block, exp_block);
                end
            end
        end
        if (in_valid && in_ready) exp_q.push_back(cur_exp);
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: run did not finish within %0d cycles", max_cycles);
        finish_run(1'b1);
    end

    initial begin
        void'($urandom(32'h73b2));
        rst      = 1'b0;
        key_load = 1'b0;
        key      = '0;
        in_valid = 1'b0;
        in_block = '0;
        cur_exp  = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        assert (!out_valid && !key_ready && !in_ready)
        else begin
            errors++;
            $error("handshake outputs not low after reset");
        end

        load_key(c1_key, 0);
        send_block(c1_pt, c1_ct);
        drain_pipeline();

        // back to back, more than eleven in flight.
        load_key(b_key, 0);
        for (int i = 0; i < 15; i++) send_block(b_pt[i % 5], b_ct[i % 5]);
        drain_pipeline();

        for (int i = 0; i < 15; i++) begin
            send_block(b_pt[(i + 2) % 5], b_ct[(i + 2) % 5]);
            idle_cycles($urandom % 4);
        end
        drain_pipeline();

        load_key('0, 6);
        send_block('0, zero_ct);
        drain_pipeline();

        @(posedge clk);
        assert (exp_q.size() == 0)
        else begin
            errors++;
            $error("%0d expected blocks never came out", exp_q.size());
        end
        finish_run(1'b0);
    end

endmodule
